// ==== vlog.f ====
+incdir+include
hw/ide_pkg.sv
hw/ide_host_port.sv
hw/ide_task_file.sv
hw/ide_sector_buffer.sv
hw/ide_read_mux.sv
hw/ide_drive_top.sv
tests/ide_drive_chk.sv
tests/ide_drive_tb.sv

// ==== Bender.yml ====
package:
  name: ide_drive

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/ide_pkg.sv
      - hw/ide_host_port.sv
      - hw/ide_task_file.sv
      - hw/ide_sector_buffer.sv
      - hw/ide_read_mux.sv
      - hw/ide_drive_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/ide_drive_chk.sv
      - tests/ide_drive_tb.sv

// ==== tests/ide_drive_tb.sv ====
// IDE drive testbench
// Host and firmware accesses through the task file and the sector buffer

`include "ide_params.svh"

module ide_drive_tb
    import ide_pkg::*;
();
    localparam int TIMEOUT_CYCLES = 10 * `SECTOR_BYTES * 8;   // Full sector of host ops, ten times

    logic      clock = 1'b0;
    logic      reset;
    logic      ide_cs1fx_n;
    logic      ide_cs3fx_n;
    logic      ide_io_read_n;
    logic      ide_io_write_n;
    ide_addr_t ide_address;
    word_t     ide_data_bus_in;
    word_t     ide_data_bus_out;
    io_addr_t  io_address;
    byte_t     io_write_data;
    logic      io_write;
    logic      io_read;
    byte_t     io_read_data;
    logic      device_master;

    int unsigned lcg_state = 8;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          start_errors = 0;
    int          cycles = 0;
    byte_t       sector [`SECTOR_BYTES];
    byte_t       values [5];
    byte_t       cmd_before;
    word_t       rd_word;
    byte_t       rd_byte;

    ide_drive_top UUT (.*);

    bind ide_drive_top ide_drive_chk u_chk (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timed out after %0d cycles before the tests finished", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic byte_t next_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic byte_t status_byte(logic bsy, logic rdy, logic drq, logic err);
        return {bsy, rdy, 2'b00, drq, 2'b00, err};
    endfunction

    function automatic byte_t drive_head_byte(byte_t v);
        return {1'b1, v[6], 1'b1, v[4], v[3:0]};
    endfunction

    function automatic byte_t drive_address_byte(byte_t v);
        return {1'b0, 1'b1, v[3:0], ~v[4], v[4]};
    endfunction

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("error %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - start_errors);
        start_errors = errors;
    endtask

    task automatic host_write(input ide_addr_t addr, input word_t data);
        @(negedge clock);
        ide_cs1fx_n = 1'b0;
        ide_address = addr;
        ide_data_bus_in = data;
        ide_io_write_n = 1'b0;
        repeat (2) @(negedge clock);
        ide_io_write_n = 1'b1;
        repeat (4) @(negedge clock);
        ide_cs1fx_n = 1'b1;
    endtask

    task automatic host_read(input ide_addr_t addr, input logic ctl, output word_t data);
        @(negedge clock);
        ide_cs1fx_n = ctl;
        ide_cs3fx_n = ~ctl;     // Control block on cs3
        ide_address = addr;
        ide_io_read_n = 1'b0;
        repeat (2) @(negedge clock);
        ide_io_read_n = 1'b1;
        repeat (4) @(negedge clock);
        data = ide_data_bus_out;
        ide_cs1fx_n = 1'b1;
        ide_cs3fx_n = 1'b1;
    endtask

    task automatic fw_write(input io_addr_t addr, input byte_t data);
        @(negedge clock);
        io_address = addr;
        io_write_data = data;
        io_write = 1'b1;
        @(negedge clock);
        io_write = 1'b0;
    endtask

    task automatic fw_read(input io_addr_t addr, output byte_t data);
        @(negedge clock);
        io_address = addr;
        io_read = 1'b1;
        #1 data = io_read_data;    // Before the pop edge
        @(negedge clock);
        io_read = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        ide_cs1fx_n = 1'b1;
        ide_cs3fx_n = 1'b1;
        ide_io_read_n = 1'b1;
        ide_io_write_n = 1'b1;
        ide_address = '0;
        ide_data_bus_in = '0;
        io_address = '0;
        io_write_data = '0;
        io_write = 1'b0;
        io_read = 1'b0;
        device_master = 1'b1;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        host_read(`REG_COMMAND, 1'b0, rd_word);
        check_value(rd_word, {8'h00, status_byte(1'b1, 1'b0, 1'b0, 1'b0)}, "reset status");
        host_read(`REG_DRIVE_HEAD, 1'b0, rd_word);
        check_value(rd_word, {8'h00, drive_head_byte(8'h00)}, "reset drive/head");
        host_read(3'd7, 1'b1, rd_word);
        check_value(rd_word, {8'h00, drive_address_byte(8'h00)}, "reset drive address");
        host_read(`REG_SECTOR_COUNT, 1'b0, rd_word);
        check_value(rd_word, 16'h0001, "reset sector count");
        host_read(`REG_SECTOR_NUMBER, 1'b0, rd_word);
        check_value(rd_word, 16'h0001, "reset sector number");
        end_test("reset values");

        for (int i = 0; i < 5; i++) begin
            values[i] = next_byte();
            host_write(ide_addr_t'(`REG_SECTOR_COUNT + i), {8'h00, values[i]});
        end
        for (int i = 0; i < 4; i++) begin
            host_read(ide_addr_t'(`REG_SECTOR_COUNT + i), 1'b0, rd_word);
            check_value(rd_word, {8'h00, values[i]}, "host register readback");
            fw_read(io_addr_t'(`IO_IDE_SECTOR_COUNT + i), rd_byte);
            check_value({8'h00, rd_byte}, {8'h00, values[i]}, "firmware register readback");
        end
        host_read(`REG_DRIVE_HEAD, 1'b0, rd_word);
        check_value(rd_word, {8'h00, drive_head_byte(values[4])}, "host drive/head");
        host_read(3'd7, 1'b1, rd_word);
        check_value(rd_word, {8'h00, drive_address_byte(values[4])}, "host drive address");
        fw_read(`IO_IDE_HEAD, rd_byte);
        check_value({8'h00, rd_byte}, {12'h000, values[4][3:0]}, "firmware head");
        fw_read(`IO_IDE_LBA, rd_byte);
        check_value({8'h00, rd_byte}, {15'h0000, values[4][6]}, "firmware lba");
        end_test("register readback");

        fw_read(`IO_IDE_COMMAND, cmd_before);
        host_write(`REG_COMMAND, 16'h0020);
        fw_read(`IO_IDE_COMMAND, rd_byte);
        check_value({8'h00, rd_byte}, {8'h00, cmd_before}, "command taken while busy");
        fw_write(`IO_IDE_STATUS, 8'h40);
        host_write(`REG_COMMAND, 16'h0030);
        fw_read(`IO_IDE_COMMAND, rd_byte);
        check_value({8'h00, rd_byte}, 16'h0030, "command after ready");
        host_read(`REG_COMMAND, 1'b0, rd_word);
        check_value(rd_word, {8'h00, status_byte(1'b1, 1'b1, 1'b0, 1'b0)}, "status after command");
        end_test("command gating");

        for (int i = 0; i < `SECTOR_BYTES; i++) begin
            sector[i] = next_byte();
            fw_write(`IO_IDE_FIFO, sector[i]);
        end
        fw_write(`IO_IDE_DATA_REQUEST, 8'h01);
        for (int k = 0; k < `SECTOR_BYTES / 2; k++) begin
            host_read(`REG_DATA, 1'b0, rd_word);
            check_value(rd_word, {sector[2*k+1], sector[2*k]}, "sector word to host");
            host_read(`REG_COMMAND, 1'b0, rd_word);
            check_value(rd_word, {8'h00, status_byte(1'b1, 1'b1, k != `SECTOR_BYTES / 2 - 1,
                        1'b0)}, "status during host read");
        end
        end_test("sector read");

        fw_write(`IO_IDE_DATA_REQUEST, 8'h01);
        for (int k = 0; k < `SECTOR_BYTES / 2; k++) begin
            sector[2*k] = next_byte();
            sector[2*k+1] = next_byte();
            host_write(`REG_DATA, {sector[2*k+1], sector[2*k]});
        end
        for (int i = 0; i < `SECTOR_BYTES; i++) begin
            fw_read(`IO_IDE_FIFO, rd_byte);
            check_value({8'h00, rd_byte}, {8'h00, sector[i]}, "sector byte to firmware");
        end
        fw_read(`IO_IDE_DATA_REQUEST, rd_byte);
        check_value({8'h00, rd_byte}, 16'h0000, "data request after write");
        end_test("sector write");

        for (int m = 0; m < 2; m++) begin
            for (int d = 0; d < 2; d++) begin
                device_master = (m == 1);
                fw_write(`IO_IDE_DRIVE, byte_t'(d));
                fw_read(`IO_IDE_DRIVE, rd_byte);
                check_value({8'h00, rd_byte}, {15'h0000, (d == 0) == (m == 1)}, "drive match");
            end
        end
        end_test("drive match");

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, UUT.u_chk.fail_count);
        if (errors == 0 && UUT.u_chk.fail_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== tests/ide_drive_chk.sv ====
// IDE drive checker
// Concurrent checks on the host read bus and the firmware read path

`include "ide_params.svh"

module ide_drive_chk
    import ide_pkg::*;
(
    input logic      clock,
    input logic      reset,
    input logic      ide_cs1fx_n,
    input logic      ide_io_read_n,
    input ide_addr_t ide_address,
    input word_t     ide_data_bus_out,
    input io_addr_t  io_address,
    input logic      io_write,
    input logic      io_read,
    input byte_t     io_read_data
);
    int         fail_count = 0;
    logic       prev_read_n;
    logic [2:0] fall_hist;      // Recent read strobe falls
    logic       status_fresh;   // No firmware status write yet

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            prev_read_n  <= 1'b1;
            fall_hist    <= 3'b000;
            status_fresh <= 1'b1;
        end else begin
            prev_read_n <= ide_io_read_n;
            fall_hist   <= {fall_hist[1:0], prev_read_n & ~ide_io_read_n};
            if (io_write && (io_address == `IO_IDE_STATUS))
                status_fresh <= 1'b0;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        !$stable(ide_data_bus_out) |-> |fall_hist)
    else begin
        fail_count++;
        $error("host read data changed with no read strobe in the last 3 cycles");
    end

    assert property (@(posedge clock) disable iff (reset)
        !io_read |-> (io_read_data == 8'h00))
    else begin
        fail_count++;
        $error("firmware read data not zero while io_read is low");
    end

    assert property (@(posedge clock) disable iff (reset)
        $fell(ide_io_read_n) && !ide_cs1fx_n && (ide_address == `REG_COMMAND) && status_fresh
        |-> ##2 ide_data_bus_out[7])
    else begin
        fail_count++;
        $error("status read after reset does not show busy");
    end

endmodule

// ==== hw/ide_drive_top.sv ====
// IDE drive top level
// Host port feeding the task file and sector buffer, joined by the read mux

module ide_drive_top
    import ide_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      ide_cs1fx_n,
    input  logic      ide_cs3fx_n,
    input  logic      ide_io_read_n,
    input  logic      ide_io_write_n,
    input  ide_addr_t ide_address,
    input  word_t     ide_data_bus_in,
    output word_t     ide_data_bus_out,
    input  io_addr_t  io_address,
    input  byte_t     io_write_data,
    input  logic      io_write,
    input  logic      io_read,
    output byte_t     io_read_data,
    input  logic      device_master
);
    ide_addr_t  host_address;
    word_t      host_data;
    logic       host_write_cmd;
    logic       host_read_cmd;
    logic       host_read_ctl;
    byte_t      sector_count;
    byte_t      sector_number;
    word_t      cylinder;
    logic [3:0] head;
    logic       drive_select;
    logic       lba_mode;
    byte_t      command;
    logic       busy;
    logic       ready;
    logic       error_flag;
    word_t      oldest_word;
    byte_t      oldest_byte;
    logic       data_request;

    ide_host_port u_host_port (.*);

    ide_task_file u_task_file (.*);

    ide_sector_buffer u_sector_buffer (.*);

    ide_read_mux u_read_mux (.*);

endmodule

// ==== hw/ide_read_mux.sv ====
// IDE read multiplexer
// Status byte, registered host read data and combinational firmware read data

`include "ide_params.svh"

module ide_read_mux
    import ide_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  byte_t      sector_count,
    input  byte_t      sector_number,
    input  word_t      cylinder,
    input  logic [3:0] head,
    input  logic       drive_select,
    input  logic       lba_mode,
    input  byte_t      command,
    input  logic       busy,
    input  logic       ready,
    input  logic       error_flag,
    input  word_t      oldest_word,
    input  byte_t      oldest_byte,
    input  logic       data_request,
    input  ide_addr_t  host_address,
    input  logic       host_read_cmd,
    input  logic       host_read_ctl,
    input  io_addr_t   io_address,
    input  logic       io_read,
    input  logic       device_master,
    output word_t      ide_data_bus_out,
    output byte_t      io_read_data
);
    byte_t status;
    byte_t drive_head;
    byte_t drive_address;
    word_t cmd_word;

    assign status        = {busy, ready, 2'b00, data_request, 2'b00, error_flag};
    assign drive_head    = {1'b1, lba_mode, 1'b1, drive_select, head};
    assign drive_address = {1'b0, 1'b1, head, ~drive_select, drive_select};

    always_comb begin
        case (host_address)
            `REG_DATA:          cmd_word = oldest_word;
            `REG_ERROR:         cmd_word = 16'h0000;
            `REG_SECTOR_COUNT:  cmd_word = {8'h00, sector_count};
            `REG_SECTOR_NUMBER: cmd_word = {8'h00, sector_number};
            `REG_CYLINDER_LOW:  cmd_word = {8'h00, cylinder[7:0]};
            `REG_CYLINDER_HIGH: cmd_word = {8'h00, cylinder[15:8]};
            `REG_DRIVE_HEAD:    cmd_word = {8'h00, drive_head};
            default:            cmd_word = {8'h00, status};
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset)
            ide_data_bus_out <= 16'hFFFF;
        else if (host_read_cmd)
            ide_data_bus_out <= cmd_word;
        else if (host_read_ctl)     // Alternate status or drive address
            ide_data_bus_out <= {8'h00, host_address[0] ? drive_address : status};
    end

    always_comb begin
        io_read_data = 8'h00;
        if (io_read) begin
            case (io_address)
                `IO_IDE_FIFO:          io_read_data = oldest_byte;
                `IO_IDE_DATA_REQUEST:  io_read_data = {7'b0000000, data_request};
                `IO_IDE_STATUS:        io_read_data = status;
                `IO_IDE_SECTOR_COUNT:  io_read_data = sector_count;
                `IO_IDE_SECTOR_NUMBER: io_read_data = sector_number;
                `IO_IDE_CYLINDER_LOW:  io_read_data = cylinder[7:0];
                `IO_IDE_CYLINDER_HIGH: io_read_data = cylinder[15:8];
                `IO_IDE_HEAD:          io_read_data = {4'h0, head};
                `IO_IDE_DRIVE:         io_read_data = {7'b0000000, drive_select == ~device_master};
                `IO_IDE_LBA:           io_read_data = {7'b0000000, lba_mode};
                `IO_IDE_COMMAND:       io_read_data = command;
                default:               io_read_data = 8'h00;
            endcase
        end
    end

endmodule

// ==== hw/ide_sector_buffer.sv ====
// IDE sector buffer
// Byte shift register shared by host and firmware, with the transfer
// counter that drives the data-request flag

`include "ide_params.svh"

module ide_sector_buffer
    import ide_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  ide_addr_t host_address,
    input  word_t     host_data,
    input  logic      host_write_cmd,
    input  logic      host_read_cmd,
    input  io_addr_t  io_address,
    input  byte_t     io_write_data,
    input  logic      io_write,
    input  logic      io_read,
    output word_t     oldest_word,
    output byte_t     oldest_byte,
    output logic      data_request
);
    localparam int DEPTH = `SECTOR_BYTES;

    byte_t       fifo [DEPTH];
    word_t       stage;
    logic [1:0]  host_shift;       // 11 low byte next, 01 high byte next
    xfer_count_t xfer_count;

    wire fw_access   = (io_address == `IO_IDE_FIFO) && (io_write || io_read);
    wire host_access = data_request && (host_address == `REG_DATA)
                       && (host_write_cmd || host_read_cmd);
    wire shift_en    = fw_access || host_shift[0];

    byte_t shift_byte;
    assign shift_byte = fw_access     ? io_write_data :
                        host_shift[1] ? stage[7:0]    : stage[15:8];

    always_ff @(posedge clock) begin
        if (host_access)
            stage <= host_data;
        if (shift_en) begin
            fifo[0] <= shift_byte;
            for (int i = 1; i < DEPTH; i++)
                fifo[i] <= fifo[i-1];
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            host_shift   <= 2'b00;
            xfer_count   <= '0;
            data_request <= 1'b0;
        end else begin
            host_shift <= host_access ? 2'b11 : {1'b0, host_shift[1]};
            if (io_write && (io_address == `IO_IDE_DATA_REQUEST))
                xfer_count <= xfer_count_t'(DEPTH);
            else if (data_request && shift_en && (xfer_count != '0))
                xfer_count <= xfer_count - 1'b1;
            if (io_write && (io_address == `IO_IDE_DATA_REQUEST))
                data_request <= io_write_data[0];
            else if (xfer_count == '0)
                data_request <= 1'b0;   // Sector done
        end
    end

    assign oldest_byte = fifo[DEPTH-1];
    assign oldest_word = {fifo[DEPTH-2], fifo[DEPTH-1]};

endmodule

// ==== hw/ide_task_file.sv ====
// IDE task file
// Command block registers loaded from the host or the firmware,
// with the busy, ready and error flags of the status byte

`include "ide_params.svh"

module ide_task_file
    import ide_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  ide_addr_t  host_address,
    input  word_t      host_data,
    input  logic       host_write_cmd,
    input  io_addr_t   io_address,
    input  byte_t      io_write_data,
    input  logic       io_write,
    output byte_t      sector_count,
    output byte_t      sector_number,
    output word_t      cylinder,
    output logic [3:0] head,
    output logic       drive_select,
    output logic       lba_mode,
    output byte_t      command,
    output logic       busy,
    output logic       ready,
    output logic       error_flag
);
    byte_t host_byte;

    assign host_byte = host_data[7:0];

    wire host_wr_count   = host_write_cmd && (host_address == `REG_SECTOR_COUNT);
    wire host_wr_number  = host_write_cmd && (host_address == `REG_SECTOR_NUMBER);
    wire host_wr_cyl_lo  = host_write_cmd && (host_address == `REG_CYLINDER_LOW);
    wire host_wr_cyl_hi  = host_write_cmd && (host_address == `REG_CYLINDER_HIGH);
    wire host_wr_head    = host_write_cmd && (host_address == `REG_DRIVE_HEAD);
    wire host_wr_command = host_write_cmd && (host_address == `REG_COMMAND);

    wire io_wr_count   = io_write && (io_address == `IO_IDE_SECTOR_COUNT);
    wire io_wr_number  = io_write && (io_address == `IO_IDE_SECTOR_NUMBER);
    wire io_wr_cyl_lo  = io_write && (io_address == `IO_IDE_CYLINDER_LOW);
    wire io_wr_cyl_hi  = io_write && (io_address == `IO_IDE_CYLINDER_HIGH);
    wire io_wr_head    = io_write && (io_address == `IO_IDE_HEAD);
    wire io_wr_drive   = io_write && (io_address == `IO_IDE_DRIVE);
    wire io_wr_lba     = io_write && (io_address == `IO_IDE_LBA);
    wire io_wr_command = io_write && (io_address == `IO_IDE_COMMAND);
    wire io_wr_status  = io_write && (io_address == `IO_IDE_STATUS);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sector_count  <= 8'h01;
            sector_number <= 8'h01;
            cylinder      <= 16'h0000;
            head          <= 4'h0;
            drive_select  <= 1'b0;
            lba_mode      <= 1'b0;
            command       <= 8'h00;
        end else begin
            if (host_wr_count)
                sector_count <= host_byte;
            else if (io_wr_count)
                sector_count <= io_write_data;

            if (host_wr_number)
                sector_number <= host_byte;
            else if (io_wr_number)
                sector_number <= io_write_data;

            if (host_wr_cyl_lo)
                cylinder[7:0] <= host_byte;
            else if (io_wr_cyl_lo)
                cylinder[7:0] <= io_write_data;

            if (host_wr_cyl_hi)
                cylinder[15:8] <= host_byte;
            else if (io_wr_cyl_hi)
                cylinder[15:8] <= io_write_data;

            if (host_wr_head) begin
                head         <= host_byte[3:0];
                drive_select <= host_byte[4];
                lba_mode     <= host_byte[6];
            end else begin
                if (io_wr_head)
                    head <= io_write_data[3:0];
                if (io_wr_drive)
                    drive_select <= io_write_data[0];
                if (io_wr_lba)
                    lba_mode <= io_write_data[0];
            end

            if (host_wr_command && !busy)   // Dropped while a command runs
                command <= host_byte;
            else if (io_wr_command)
                command <= io_write_data;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            busy       <= 1'b1;
            ready      <= 1'b0;
            error_flag <= 1'b0;
        end else begin
            if (host_wr_command)
                busy <= 1'b1;
            else if (io_wr_status)
                busy <= io_write_data[7];
            if (io_wr_status) begin
                ready      <= io_write_data[6];
                error_flag <= io_write_data[0];
            end
        end
    end

endmodule

// ==== hw/ide_host_port.sv ====
// IDE host port
// Latches the host address and data, turns the strobes into one-cycle pulses

module ide_host_port
    import ide_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      ide_cs1fx_n,
    input  logic      ide_cs3fx_n,
    input  logic      ide_io_read_n,
    input  logic      ide_io_write_n,
    input  ide_addr_t ide_address,
    input  word_t     ide_data_bus_in,
    output ide_addr_t host_address,
    output word_t     host_data,
    output logic      host_write_cmd,
    output logic      host_read_cmd,
    output logic      host_read_ctl
);
    logic prev_read_n;
    logic prev_write_n;
    logic command_cs;

    always_ff @(posedge clock) begin
        if (~ide_cs1fx_n | ~ide_cs3fx_n) begin
            host_address <= ide_address;
            host_data    <= ide_data_bus_in;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            prev_read_n    <= 1'b1;
            prev_write_n   <= 1'b1;
            command_cs     <= 1'b0;
            host_write_cmd <= 1'b0;
            host_read_cmd  <= 1'b0;
            host_read_ctl  <= 1'b0;
        end else begin
            prev_read_n    <= ide_io_read_n;
            prev_write_n   <= ide_io_write_n;
            command_cs     <= ~ide_cs1fx_n;
            host_write_cmd <= command_cs & ~prev_write_n & ide_io_write_n;    // Trailing edge
            host_read_cmd  <= prev_read_n & ~ide_io_read_n & ~ide_cs1fx_n;
            host_read_ctl  <= prev_read_n & ~ide_io_read_n & ~ide_cs3fx_n;
        end
    end

endmodule

// ==== hw/ide_pkg.sv ====
// IDE drive package
// Vector types shared by the host port, task file, buffer and read paths

package ide_pkg;

    // Task file registers and firmware bus data
    typedef logic [7:0] byte_t;

    // Host data bus
    typedef logic [15:0] word_t;

    // Host register select
    typedef logic [2:0] ide_addr_t;

    // Firmware bus address
    typedef logic [7:0] io_addr_t;

    // Bytes left in the current sector transfer
    typedef logic [15:0] xfer_count_t;

endpackage

// ==== include/ide_params.svh ====
// IDE drive parameters
// Buffer depth, host task-file addresses and firmware I/O addresses

`ifndef IDE_PARAMS_SVH
`define IDE_PARAMS_SVH

`define SECTOR_BYTES            512

// Host command block registers
`define REG_DATA                3'd0
`define REG_ERROR               3'd1
`define REG_SECTOR_COUNT        3'd2
`define REG_SECTOR_NUMBER       3'd3
`define REG_CYLINDER_LOW        3'd4
`define REG_CYLINDER_HIGH       3'd5
`define REG_DRIVE_HEAD          3'd6
`define REG_COMMAND             3'd7    // Status on read

// Firmware I/O bus
`define IO_IDE_FIFO             8'hC1
`define IO_IDE_DATA_REQUEST     8'hC2
`define IO_IDE_STATUS           8'hC3
`define IO_IDE_SECTOR_COUNT     8'hC6
`define IO_IDE_SECTOR_NUMBER    8'hC7
`define IO_IDE_CYLINDER_LOW     8'hC8
`define IO_IDE_CYLINDER_HIGH    8'hC9
`define IO_IDE_HEAD             8'hCA
`define IO_IDE_DRIVE            8'hCB
`define IO_IDE_LBA              8'hCC
`define IO_IDE_COMMAND          8'hCD

`endif
